// ==== src/touch_pkg.sv ====
package touch_pkg;

	// command bytes: start bit, channel select, 12-bit mode, differential ref
	localparam logic [7:0] CMD_X  = 8'hD0;
	localparam logic [7:0] CMD_Y  = 8'h90;
	localparam logic [7:0] CMD_Z1 = 8'hB0;

	// serial frame layout, counted in touch_clk periods
	localparam int TOUCH_CMD_BITS     = 8;
	localparam int TOUCH_RESULT_BITS  = 12;
	// first period index (zero based) that carries a result bit
	localparam int TOUCH_RESULT_FIRST = 8;
	localparam int TOUCH_PERIODS      = 24;

	// cclk cycles per touch_clk half period
	localparam int TOUCH_HALF_DIV = 2;
	// cclk cycles with csb high between conversions
	localparam int TOUCH_GAP      = 2;

	// z1 at or above this counts as a press
	localparam logic [11:0] PRESS_THRESHOLD = 12'd200;

	// raw adc to screen scaling
	localparam int COL_SHIFT = 3;
	localparam int ROW_SHIFT = 4;

	// one full X/Y/Z1 sweep, raw results
	typedef struct packed {
		logic [TOUCH_RESULT_BITS-1:0] x;
		logic [TOUCH_RESULT_BITS-1:0] y;
		logic [TOUCH_RESULT_BITS-1:0] z;
	} touch_sample_t;

	// crosshair position in screen pixels
	typedef struct packed {
		logic       active;
		logic [8:0] col;
		logic [8:0] row;
	} cursor_t;

endpackage

// ==== src/tft_pkg.sv ====
package tft_pkg;

	// horizontal raster, in pixel clocks
	localparam int H_ACTIVE = 480;
	localparam int H_TOTAL  = 525;

	// vertical raster, in lines
	localparam int V_ACTIVE = 272;
	localparam int V_TOTAL  = 286;

	// power-up spacing, in cclk cycles
	localparam int VDD_TO_DISP = 64;
	localparam int DISP_TO_BL  = 64;
	// wide enough for either delay
	localparam int PWR_CNT_W   = 7;

	// raster counter widths
	localparam int COL_W = 10;
	localparam int ROW_W = 9;

	// current raster position
	typedef struct packed {
		logic [COL_W-1:0] col;
		logic [ROW_W-1:0] row;
	} tft_pos_t;

	// 24-bit panel colour
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage

// ==== src/touch_spi_ctrl.sv ====
`timescale 1ns/1ps

module touch_spi_ctrl (
	input  logic                     cclk,
	input  logic                     rst_n,
	input  logic                     touch_data_out,
	output logic                     touch_csb,
	output logic                     touch_clk,
	output logic                     touch_data_in,
	output touch_pkg::touch_sample_t sample,
	output logic                     sample_valid
);
	import touch_pkg::*;

	typedef enum logic {ST_GAP, ST_XFER} state_t;
	typedef enum logic [1:0] {CH_X, CH_Y, CH_Z1} chan_t;

	state_t                       state;
	chan_t                        chan;
	logic [1:0]                   gap_cnt;
	logic [1:0]                   half_cnt;
	logic [4:0]                   bit_cnt;
	logic [TOUCH_CMD_BITS-1:0]    cmd_byte;
	logic [TOUCH_CMD_BITS-1:0]    cmd_sr;
	logic [TOUCH_RESULT_BITS-1:0] result_sr;
	logic [TOUCH_RESULT_BITS-1:0] raw_x;
	logic [TOUCH_RESULT_BITS-1:0] raw_y;
	logic                         half_done;
	logic                         rise_now;
	logic                         period_end;
	logic                         conv_done;
	logic                         result_bit;

	// command for the channel about to be converted
	always_comb begin
		case (chan)
			CH_X:    cmd_byte = CMD_X;
			CH_Y:    cmd_byte = CMD_Y;
			default: cmd_byte = CMD_Z1;
		endcase
	end

	// end of a touch_clk half period
	assign half_done  = (state == ST_XFER) && (half_cnt == 2'(TOUCH_HALF_DIV - 1));
	// low half ending, clock about to rise
	assign rise_now   = half_done && !touch_clk;
	// high half ending, period over
	assign period_end = half_done && touch_clk;
	assign conv_done  = period_end && (bit_cnt == 5'(TOUCH_PERIODS - 1));
	// periods 9..20 carry the result, msb first
	assign result_bit = rise_now && (bit_cnt >= 5'(TOUCH_RESULT_FIRST)) &&
		(bit_cnt < 5'(TOUCH_RESULT_FIRST + TOUCH_RESULT_BITS));

	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			state         <= ST_GAP;
			chan          <= CH_X;
			gap_cnt       <= '0;
			half_cnt      <= '0;
			bit_cnt       <= '0;
			cmd_sr        <= '0;
			touch_csb     <= 1'b1;
			touch_clk     <= 1'b1;
			touch_data_in <= 1'b0;
			sample_valid  <= 1'b0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				ST_GAP: begin
					if (gap_cnt == 2'(TOUCH_GAP - 1)) begin
						// open the conversion with clock low and command msb
						state         <= ST_XFER;
						gap_cnt       <= '0;
						half_cnt      <= '0;
						bit_cnt       <= '0;
						touch_csb     <= 1'b0;
						touch_clk     <= 1'b0;
						touch_data_in <= cmd_byte[TOUCH_CMD_BITS-1];
						cmd_sr        <= cmd_byte << 1;
					end else begin
						gap_cnt <= gap_cnt + 2'd1;
					end
				end
				ST_XFER: begin
					if (!half_done) begin
						half_cnt <= half_cnt + 2'd1;
					end else begin
						half_cnt <= '0;
						if (rise_now) begin
							touch_clk <= 1'b1;
						end else if (conv_done) begin
							// release csb, clock already high
							state         <= ST_GAP;
							touch_csb     <= 1'b1;
							touch_data_in <= 1'b0;
							sample_valid  <= (chan == CH_Z1);
							case (chan)
								CH_X:    chan <= CH_Y;
								CH_Y:    chan <= CH_Z1;
								default: chan <= CH_X;
							endcase
						end else begin
							// next period, data moves while clock is low
							bit_cnt       <= bit_cnt + 5'd1;
							touch_clk     <= 1'b0;
							// shifter runs empty after the command, so data stays low
							touch_data_in <= cmd_sr[TOUCH_CMD_BITS-1];
							cmd_sr        <= cmd_sr << 1;
						end
					end
				end
				default: state <= ST_GAP;
			endcase
		end
	end

	// result shifter and per-channel holding registers
	always_ff @(posedge cclk) begin
		if (result_bit) begin
			result_sr <= {result_sr[TOUCH_RESULT_BITS-2:0], touch_data_out};
		end
		if (conv_done) begin
			case (chan)
				CH_X:    raw_x <= result_sr;
				CH_Y:    raw_y <= result_sr;
				// sample only moves together with the strobe
				default: sample <= '{x: raw_x, y: raw_y, z: result_sr};
			endcase
		end
	end

endmodule

// ==== src/touch_locker.sv ====
`timescale 1ns/1ps

module touch_locker (
	input  logic                     cclk,
	input  logic                     rst_n,
	input  touch_pkg::touch_sample_t sample,
	input  logic                     sample_valid,
	input  logic                     frame_end,
	output touch_pkg::cursor_t       cursor
);
	import touch_pkg::*;
	import tft_pkg::*;

	logic [TOUCH_RESULT_BITS-1:0] x_scaled;
	logic [TOUCH_RESULT_BITS-1:0] y_scaled;
	cursor_t                      next_cursor;
	cursor_t                      pend;

	// raw 12-bit readings down to pixel units
	assign x_scaled = sample.x >> COL_SHIFT;
	assign y_scaled = sample.y >> ROW_SHIFT;

	always_comb begin
		// light pressure means no touch
		next_cursor.active = (sample.z >= PRESS_THRESHOLD);
		// x full scale lands past the right edge
		if (x_scaled > TOUCH_RESULT_BITS'(H_ACTIVE - 1)) begin
			next_cursor.col = 9'(H_ACTIVE - 1);
		end else begin
			next_cursor.col = x_scaled[8:0];
		end
		// y tops out at 255, always on screen
		next_cursor.row = y_scaled[8:0];
	end

	// latest strobe wins until the frame ends
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			pend <= '0;
		end else if (sample_valid) begin
			pend <= next_cursor;
		end
	end

	// cursor only moves between frames
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			cursor <= '0;
		end else if (frame_end) begin
			cursor <= pend;
		end
	end

endmodule

// ==== src/tft_timing.sv ====
`timescale 1ns/1ps

module tft_timing (
	input  logic              cclk,
	input  logic              rst_n,
	output logic              tft_vdd,
	output logic              tft_display,
	output logic              tft_backlight,
	output tft_pkg::tft_pos_t pos,
	output logic              active,
	output logic              frame_end
);
	import tft_pkg::*;

	logic [PWR_CNT_W-1:0] pwr_cnt;
	logic [COL_W-1:0]     h_cnt;
	logic [ROW_W-1:0]     v_cnt;
	logic                 h_last;
	logic                 v_last;

	// power-up: vdd, then display, then backlight
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			tft_vdd       <= 1'b0;
			tft_display   <= 1'b0;
			tft_backlight <= 1'b0;
			pwr_cnt       <= '0;
		end else if (!tft_vdd) begin
			// first cycle out of reset
			tft_vdd <= 1'b1;
			pwr_cnt <= '0;
		end else if (!tft_display) begin
			if (pwr_cnt == PWR_CNT_W'(VDD_TO_DISP - 1)) begin
				tft_display <= 1'b1;
				pwr_cnt     <= '0;
			end else begin
				pwr_cnt <= pwr_cnt + 1'b1;
			end
		end else if (!tft_backlight) begin
			if (pwr_cnt == PWR_CNT_W'(DISP_TO_BL - 1)) begin
				tft_backlight <= 1'b1;
				pwr_cnt       <= '0;
			end else begin
				pwr_cnt <= pwr_cnt + 1'b1;
			end
		end
	end

	assign h_last = (h_cnt == COL_W'(H_TOTAL - 1));
	assign v_last = (v_cnt == ROW_W'(V_TOTAL - 1));

	// raster counters, held at the origin until the display is on
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (tft_display) begin
			if (h_last) begin
				h_cnt <= '0;
				// wrap to the top after the last blank line
				if (v_last) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 1'b1;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	assign pos = '{col: h_cnt, row: v_cnt};

	// visible window, top left corner at the origin
	assign active = tft_display && (h_cnt < COL_W'(H_ACTIVE)) &&
		(v_cnt < ROW_W'(V_ACTIVE));

	// one cycle past the last visible pixel
	assign frame_end = tft_display && (h_cnt == COL_W'(H_ACTIVE)) &&
		(v_cnt == ROW_W'(V_ACTIVE - 1));

endmodule

// ==== src/tft_pixel_gen.sv ====
`timescale 1ns/1ps

module tft_pixel_gen (
	input  logic               cclk,
	input  logic               rst_n,
	input  logic [7:0]         switch,
	input  tft_pkg::tft_pos_t  pos,
	input  logic               active,
	input  touch_pkg::cursor_t cursor,
	output logic               tft_data_ena,
	output logic [7:0]         tft_red,
	output logic [7:0]         tft_green,
	output logic [7:0]         tft_blue
);
	import tft_pkg::*;

	rgb_t bg_color;
	rgb_t pix_color;
	logic col_hit;
	logic row_hit;

	// switches pick the top bits of each channel
	assign bg_color = '{
		red:   {switch[7:5], 5'b0},
		green: {switch[4:2], 5'b0},
		blue:  {switch[1:0], 6'b0}
	};

	// crosshair lines through the cursor
	assign col_hit = (pos.col == COL_W'(cursor.col));
	assign row_hit = (pos.row == cursor.row);

	always_comb begin
		if (!active) begin
			// blanking must be black
			pix_color = '0;
		end else if (cursor.active && (col_hit || row_hit)) begin
			pix_color = '1;
		end else begin
			pix_color = bg_color;
		end
	end

	// enable delayed to stay in step with the colour
	always_ff @(posedge cclk) begin
		if (!rst_n) begin
			tft_data_ena <= 1'b0;
		end else begin
			tft_data_ena <= active;
		end
	end

	always_ff @(posedge cclk) begin
		tft_red   <= pix_color.red;
		tft_green <= pix_color.green;
		tft_blue  <= pix_color.blue;
	end

endmodule

// ==== src/touch_display_top.sv ====
`timescale 1ns/1ps

module touch_display_top (
	input  logic       cclk,
	input  logic       rst_n,
	input  logic [7:0] switch,
	input  logic       touch_data_out,
	output logic       touch_csb,
	output logic       touch_clk,
	output logic       touch_data_in,
	output logic       tft_vdd,
	output logic       tft_display,
	output logic       tft_backlight,
	output logic       tft_data_ena,
	output logic [7:0] tft_red,
	output logic [7:0] tft_green,
	output logic [7:0] tft_blue
);
	import touch_pkg::*;
	import tft_pkg::*;

	// touch side
	touch_sample_t sample;
	logic          sample_valid;
	cursor_t       cursor;
	// panel side
	tft_pos_t      pos;
	logic          active;
	logic          frame_end;

	touch_spi_ctrl u_touch_spi_ctrl (
		.cclk           (cclk),
		.rst_n          (rst_n),
		.touch_data_out (touch_data_out),
		.touch_csb      (touch_csb),
		.touch_clk      (touch_clk),
		.touch_data_in  (touch_data_in),
		.sample         (sample),
		.sample_valid   (sample_valid)
	);

	// cursor updates on frame boundaries only
	touch_locker u_touch_locker (
		.cclk         (cclk),
		.rst_n        (rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.frame_end    (frame_end),
		.cursor       (cursor)
	);

	tft_timing u_tft_timing (
		.cclk          (cclk),
		.rst_n         (rst_n),
		.tft_vdd       (tft_vdd),
		.tft_display   (tft_display),
		.tft_backlight (tft_backlight),
		.pos           (pos),
		.active        (active),
		.frame_end     (frame_end)
	);

	tft_pixel_gen u_tft_pixel_gen (
		.cclk         (cclk),
		.rst_n        (rst_n),
		.switch       (switch),
		.pos          (pos),
		.active       (active),
		.cursor       (cursor),
		.tft_data_ena (tft_data_ena),
		.tft_red      (tft_red),
		.tft_green    (tft_green),
		.tft_blue     (tft_blue)
	);

endmodule

// ==== testbench/touch_adc_model.sv ====
`timescale 1ns/1ps

module touch_adc_model (
	input  logic        touch_csb,
	input  logic        touch_clk,
	input  logic        touch_data_in,
	input  logic [11:0] x_val,
	input  logic [11:0] y_val,
	input  logic [11:0] z_val,
	output logic        touch_data_out,
	output logic        fault
);
	// conversion state, kept in one process
	logic [4:0]  rises     = 5'd0;
	logic [7:0]  cmd       = 8'd0;
	logic [11:0] result_sr = 12'd0;
	logic [1:0]  expect_ch = 2'd0;
	logic [2:0]  expect_a  = 3'b101;
	logic        in_conv   = 1'b0;
	logic        csb_q     = 1'b1;
	logic        dout      = 1'b0;
	logic        bad       = 1'b0;

	assign touch_data_out = dout;
	assign fault          = bad;

	always @(posedge touch_csb or negedge touch_csb or posedge touch_clk) begin
		if (touch_csb !== csb_q) begin
			csb_q = touch_csb;
			if (touch_csb === 1'b0) begin
				// new conversion, count rising clocks from zero
				in_conv = 1'b1;
				rises   = 5'd0;
				dout    = 1'b0;
			end else if (in_conv) begin
				in_conv = 1'b0;
				dout    = 1'b0;
				if (rises != 5'd24) begin
					$display("touch ADC model: conversion had %0d clocks instead of 24", rises);
					bad = 1'b1;
				end
				// X, Y, Z1, then around again
				expect_ch = (expect_ch == 2'd2) ? 2'd0 : expect_ch + 2'd1;
			end
		end else if (in_conv && touch_clk === 1'b1) begin
			// command bits arrive on the first eight rising edges
			if (rises < 5'd8) begin
				cmd = {cmd[6:0], touch_data_in};
			end
			rises = rises + 5'd1;
			if (rises == 5'd8) begin
				case (expect_ch)
					2'd0:    expect_a = 3'b101;
					2'd1:    expect_a = 3'b001;
					default: expect_a = 3'b011;
				endcase
				if (cmd[7] !== 1'b1) begin
					$display("touch ADC model: command %h has no start bit", cmd);
					bad = 1'b1;
				end
				if (cmd[6:4] !== expect_a) begin
					$display("touch ADC model: channel bits %b out of order", cmd[6:4]);
					bad = 1'b1;
				end
				case (expect_ch)
					2'd0:    result_sr = x_val;
					2'd1:    result_sr = y_val;
					default: result_sr = z_val;
				endcase
			end
			// result msb ready one period before the controller samples it
			if (rises >= 5'd8 && rises <= 5'd19) begin
				dout      = result_sr[11];
				result_sr = result_sr << 1;
			end else begin
				dout = 1'b0;
			end
		end
	end

endmodule

// ==== testbench/tb_touch_display.sv ====
`timescale 1ns/1ps

module tb_touch_display;

	localparam int NUM_ENTRIES = 6;
	// three frames per entry plus margin
	localparam int CYCLE_LIMIT = 8 * NUM_ENTRIES * 525 * 286 + 1000;

	typedef struct packed {
		logic [11:0] x;
		logic [11:0] y;
		logic [11:0] z;
		logic [7:0]  sw;
		logic        act;
		logic [8:0]  col;
		logic [8:0]  row;
	} entry_t;

	logic        cclk;
	logic        rst_n;
	logic [7:0]  switch;
	logic        touch_data_out;
	logic        touch_csb;
	logic        touch_clk;
	logic        touch_data_in;
	logic        tft_vdd;
	logic        tft_display;
	logic        tft_backlight;
	logic        tft_data_ena;
	logic [7:0]  tft_red;
	logic [7:0]  tft_green;
	logic [7:0]  tft_blue;
	logic [11:0] x_val;
	logic [11:0] y_val;
	logic [11:0] z_val;
	logic        adc_fault;

	entry_t      table_e [NUM_ENTRIES];
	entry_t      cur;
	int          cycle_cnt;
	int          cyc_since_rst;
	int          vdd_cyc;
	int          disp_cyc;
	logic        vdd_seen;
	logic        disp_seen;
	logic        bl_seen;
	// tracked raster position of the next enabled pixel
	logic [9:0]  pix_col;
	logic [8:0]  pix_row;

	touch_display_top u_touch_display_top (
		.cclk           (cclk),
		.rst_n          (rst_n),
		.switch         (switch),
		.touch_data_out (touch_data_out),
		.touch_csb      (touch_csb),
		.touch_clk      (touch_clk),
		.touch_data_in  (touch_data_in),
		.tft_vdd        (tft_vdd),
		.tft_display    (tft_display),
		.tft_backlight  (tft_backlight),
		.tft_data_ena   (tft_data_ena),
		.tft_red        (tft_red),
		.tft_green      (tft_green),
		.tft_blue       (tft_blue)
	);

	touch_adc_model u_touch_adc_model (
		.touch_csb      (touch_csb),
		.touch_clk      (touch_clk),
		.touch_data_in  (touch_data_in),
		.x_val          (x_val),
		.y_val          (y_val),
		.z_val          (z_val),
		.touch_data_out (touch_data_out),
		.fault          (adc_fault)
	);

	always #2 cclk = ~cclk;

	task automatic stop_fail(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// cursor from raw readings by threshold, shift and clamp
	function automatic logic [18:0] scaled_cursor(input logic [11:0] x,
			input logic [11:0] y, input logic [11:0] z);
		logic [11:0] xs;
		logic [11:0] ys;
		logic [8:0]  col;
		xs = x >> 3;
		ys = y >> 4;
		col = (xs > 12'd479) ? 9'd479 : xs[8:0];
		return {(z >= 12'd200), col, ys[8:0]};
	endfunction

	function automatic logic [23:0] expected_rgb(input entry_t e, input logic [9:0] col,
			input logic [8:0] row);
		if (e.act && (col == {1'b0, e.col} || row == e.row)) begin
			return 24'hFFFFFF;
		end
		return {e.sw[7:5], 5'b0, e.sw[4:2], 5'b0, e.sw[1:0], 6'b0};
	endfunction

	// power checks then pixel tracking on one falling edge
	task automatic tick(input logic check, output logic frame_done);
		logic [23:0] exp_rgb;
		@(negedge cclk);
		cyc_since_rst++;
		if (tft_vdd && !vdd_seen) begin
			vdd_seen = 1'b1;
			vdd_cyc  = cyc_since_rst;
			assert (cyc_since_rst == 1) else
				stop_fail($sformatf("FAIL t=%0t tft_vdd rise cycle expected=1 actual=%0d",
					$time, cyc_since_rst));
		end
		if (tft_display && !disp_seen) begin
			disp_seen = 1'b1;
			disp_cyc  = cyc_since_rst;
			assert (vdd_seen && cyc_since_rst == vdd_cyc + 64) else
				stop_fail($sformatf("FAIL t=%0t tft_display rise cycle expected=%0d actual=%0d",
					$time, vdd_cyc + 64, cyc_since_rst));
		end
		if (tft_backlight && !bl_seen) begin
			bl_seen = 1'b1;
			assert (disp_seen && cyc_since_rst == disp_cyc + 64) else
				stop_fail($sformatf("FAIL t=%0t tft_backlight rise cycle expected=%0d actual=%0d",
					$time, disp_cyc + 64, cyc_since_rst));
		end
		assert (!(tft_data_ena && !tft_display)) else
			stop_fail("tft_data_ena went high before the display was switched on");
		frame_done = 1'b0;
		if (tft_data_ena) begin
			if (check) begin
				exp_rgb = expected_rgb(cur, pix_col, pix_row);
				assert ({tft_red, tft_green, tft_blue} == exp_rgb) else
					stop_fail($sformatf("FAIL t=%0t rgb at col %0d row %0d expected=%h actual=%h",
						$time, pix_col, pix_row, exp_rgb, {tft_red, tft_green, tft_blue}));
			end
			// row-major walk over the visible window
			if (pix_col == 10'd479) begin
				pix_col = 10'd0;
				if (pix_row == 9'd271) begin
					pix_row    = 9'd0;
					frame_done = 1'b1;
				end else begin
					pix_row = pix_row + 9'd1;
				end
			end else begin
				pix_col = pix_col + 10'd1;
			end
		end else begin
			// blanking is black
			assert ({tft_red, tft_green, tft_blue} == 24'h000000) else
				stop_fail($sformatf("FAIL t=%0t rgb in blanking expected=000000 actual=%h",
					$time, {tft_red, tft_green, tft_blue}));
		end
	endtask

	task automatic wait_frame(input logic check);
		logic done;
		done = 1'b0;
		while (!done) begin
			tick(check, done);
		end
	endtask

	// run limit
	always @(posedge cclk) begin
		cycle_cnt++;
		assert (cycle_cnt < CYCLE_LIMIT) else
			stop_fail("timeout, the run did not finish within the cycle limit");
	end

	// fault seen by the ADC model
	always @(negedge cclk) begin
		assert (!adc_fault) else
			stop_fail("touch ADC model received a malformed or out of order command");
	end

	initial begin
		cclk          = 1'b0;
		rst_n         = 1'b0;
		switch        = 8'h00;
		x_val         = 12'd0;
		y_val         = 12'd0;
		z_val         = 12'd0;
		cycle_cnt     = 0;
		cyc_since_rst = 0;
		vdd_cyc       = 0;
		disp_cyc      = 0;
		vdd_seen      = 1'b0;
		disp_seen     = 1'b0;
		bl_seen       = 1'b0;
		pix_col       = 10'd0;
		pix_row       = 9'd0;
		cur           = '0;
		// idle, idle, mid press, clamped press, release, threshold press
		table_e[0] = '{x: 12'd2000, y: 12'd2000, z: 12'd50, sw: 8'hE4,
			act: 1'b0, col: 9'd250, row: 9'd125};
		table_e[1] = '{x: 12'd1000, y: 12'd3000, z: 12'd100, sw: 8'h1B,
			act: 1'b0, col: 9'd125, row: 9'd187};
		table_e[2] = '{x: 12'd1920, y: 12'd2176, z: 12'd900, sw: 8'h92,
			act: 1'b1, col: 9'd240, row: 9'd136};
		table_e[3] = '{x: 12'd4000, y: 12'd800, z: 12'd1500, sw: 8'h49,
			act: 1'b1, col: 9'd479, row: 9'd50};
		table_e[4] = '{x: 12'd1000, y: 12'd1000, z: 12'd150, sw: 8'h6D,
			act: 1'b0, col: 9'd125, row: 9'd62};
		table_e[5] = '{x: 12'd2520, y: 12'd4095, z: 12'd200, sw: 8'hB6,
			act: 1'b1, col: 9'd315, row: 9'd255};
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			assert (scaled_cursor(table_e[i].x, table_e[i].y, table_e[i].z) ==
				{table_e[i].act, table_e[i].col, table_e[i].row}) else
				stop_fail($sformatf("table entry %0d disagrees with the scaling rule", i));
		end
		repeat (2) @(negedge cclk);
		// outputs held in their reset state
		assert ({tft_vdd, tft_display, tft_backlight, tft_data_ena} == 4'b0000) else
			stop_fail($sformatf(
				"FAIL t=%0t {tft_vdd,tft_display,tft_backlight,tft_data_ena} expected=0000 actual=%b",
				$time, {tft_vdd, tft_display, tft_backlight, tft_data_ena}));
		assert ({touch_csb, touch_clk, touch_data_in} == 3'b110) else
			stop_fail($sformatf(
				"FAIL t=%0t {touch_csb,touch_clk,touch_data_in} expected=110 actual=%b",
				$time, {touch_csb, touch_clk, touch_data_in}));
		rst_n = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			cur    = table_e[i];
			x_val  = cur.x;
			y_val  = cur.y;
			z_val  = cur.z;
			switch = cur.sw;
			// latch during one frame, show in the next, check the one after
			wait_frame(1'b0);
			wait_frame(1'b0);
			wait_frame(1'b1);
		end
		if (bl_seen) begin
			$display("TB PASSED");
			$finish;
		end else begin
			stop_fail("tft_backlight never came on");
		end
	end

endmodule

// ==== verilog.f ====
src/touch_pkg.sv
src/tft_pkg.sv
src/touch_spi_ctrl.sv
src/touch_locker.sv
src/tft_timing.sv
src/tft_pixel_gen.sv
src/touch_display_top.sv
testbench/touch_adc_model.sv
testbench/tb_touch_display.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_touch_display \
	-o Vtb_touch_display > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_touch_display > sim.log 2>&1
cat sim.log

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0
